/* lsu_core.f */
hdl/lsu_pkg.sv
hdl/lsu_mem_if.sv
hdl/lsu_op_decode.sv
hdl/exu_agu_lsu.sv
hdl/lsu_data_ram.sv
hdl/lsu_reg_file.sv
hdl/lsu_top.sv
dv/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the LSU testbench with Verilator and run it.
# The run passes only if the simulation prints its pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module lsu_tb -f lsu_core.f -o lsu_sim \
    && ./obj_dir/lsu_sim | tee /dev/stderr | grep -qx "Finished with no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* dv/lsu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for the load/store slice.
// Each row is issued for one cycle, then its rd is read back through
// the register-file port and compared with a byte-level memory model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;

    localparam logic [1:0] K_STORE     = 2'd0;
    localparam logic [1:0] K_LOAD      = 2'd1;
    localparam logic [1:0] K_INT_STORE = 2'd2;
    localparam logic [1:0] K_INT_LOAD  = 2'd3;
    localparam int RESET_TIMEOUT = 50;

    typedef struct packed {
        logic [1:0]  kind;
        logic [2:0]  funct3;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] rs2;
        logic [4:0]  rd;
        logic        b2b;
        logic [31:0] exp_rd;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        req;
    logic        load;
    logic        store;
    logic [2:0]  funct3;
    logic [31:0] base;
    logic [31:0] offset;
    logic [31:0] rs2_data;
    logic [4:0]  rd_addr;
    logic        int_assert;
    logic [4:0]  rf_raddr;
    logic [31:0] rf_rdata;

    row_t        rows [$];
    logic [7:0]  mem_model [1024];
    logic [31:0] reg_model [32];
    int          seed;
    int          pass_cnt;
    int          fail_cnt;

    lsu_top u_lsu_top (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .req_i        (req),
        .load_i       (load),
        .store_i      (store),
        .funct3_i     (funct3),
        .base_i       (base),
        .offset_i     (offset),
        .rs2_data_i   (rs2_data),
        .rd_addr_i    (rd_addr),
        .int_assert_i (int_assert),
        .rf_raddr_i   (rf_raddr),
        .rf_rdata_o   (rf_rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
    end

    function automatic void add_row(input logic [1:0] kind, input logic [2:0] f3,
            input logic [31:0] b, input logic [31:0] off, input logic [31:0] d,
            input logic [4:0] rd, input logic b2b);
        row_t r;
        r = '{kind, f3, b, off, d, rd, b2b, 32'd0};
        rows.push_back(r);
    endfunction

    // byte-wide memory model covering the 256 RAM words
    function automatic void model_store(input logic [2:0] f3, input logic [31:0] addr,
            input logic [31:0] d);
        logic [9:0] a;
        logic [9:0] ha;
        a  = addr[9:0];
        // halfword position from address bit 1 only
        ha = {a[9:2], a[1], 1'b0};
        case (f3)
            lsu_pkg::F3_SB: mem_model[a] = d[7:0];
            lsu_pkg::F3_SH: begin
                mem_model[ha] = d[7:0];
                mem_model[{ha[9:1], 1'b1}] = d[15:8];
            end
            lsu_pkg::F3_SW: begin
                for (int k = 0; k < 4; k++) begin
                    mem_model[{a[9:2], 2'(k)}] = d[k*8 +: 8];
                end
            end
            default: ;
        endcase
    endfunction

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        a = addr[9:0];
        b = mem_model[a];
        h = {mem_model[{a[9:1], 1'b1}], mem_model[{a[9:1], 1'b0}]};
        w = {mem_model[{a[9:2], 2'd3}], mem_model[{a[9:2], 2'd2}],
             mem_model[{a[9:2], 2'd1}], mem_model[{a[9:2], 2'd0}]};
        case (f3)
            lsu_pkg::F3_LB:  return {{24{b[7]}}, b};
            lsu_pkg::F3_LBU: return {24'd0, b};
            lsu_pkg::F3_LH:  return {{16{h[15]}}, h};
            lsu_pkg::F3_LHU: return {16'd0, h};
            lsu_pkg::F3_LW:  return w;
            default:         return 32'd0;
        endcase
    endfunction

    // updates the model for one row and gives the expected rd contents
    function automatic logic [31:0] model_apply(input row_t r);
        logic [31:0] addr;
        addr = r.base + r.offset;
        if (r.kind == K_STORE) begin
            model_store(r.funct3, addr, r.rs2);
        end else if (r.kind == K_LOAD && r.rd != 5'd0) begin
            reg_model[r.rd] = model_load(r.funct3, addr);
        end
        return (r.rd == 5'd0) ? 32'd0 : reg_model[r.rd];
    endfunction

    task automatic compare(input logic [4:0] rd, input logic [31:0] want, inout bit ok);
        assert (rf_rdata === want) else begin
            $display("[FAIL] %0t ns: rf_rdata_o (x%0d) expected %08h, got %08h",
                     $time, rd, want, rf_rdata);
            ok = 1'b0;
        end
    endtask

    task automatic tally(input string what, input bit ok);
        if (ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("%-56s %s", what, ok ? "ok" : "FAILED");
    endtask

    task automatic issue(input logic [1:0] kind, input logic [2:0] f3, input logic [31:0] b,
            input logic [31:0] off, input logic [31:0] d, input logic [4:0] rd);
        @(posedge clk);
        req        <= 1'b1;
        load       <= (kind == K_LOAD) || (kind == K_INT_LOAD);
        store      <= (kind == K_STORE) || (kind == K_INT_STORE);
        int_assert <= (kind == K_INT_STORE) || (kind == K_INT_LOAD);
        funct3     <= f3;
        base       <= b;
        offset     <= off;
        rs2_data   <= d;
        rd_addr    <= rd;
    endtask

    // idle cycle after an access with rd sampled mid-cycle
    task automatic read_back(input logic [4:0] rd, input logic [31:0] want, inout bit ok);
        @(posedge clk);
        req        <= 1'b0;
        load       <= 1'b0;
        store      <= 1'b0;
        int_assert <= 1'b0;
        rf_raddr   <= rd;
        @(negedge clk);
        compare(rd, want, ok);
    endtask

    task automatic check_reset();
        bit ok;
        ok = 1'b1;
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            rf_raddr <= 5'(r);
            @(negedge clk);
            compare(5'(r), 32'd0, ok);
        end
        // every RAM word through a word load into x1
        for (int w = 0; w < lsu_pkg::RAM_DEPTH; w++) begin
            issue(K_LOAD, lsu_pkg::F3_LW, 32'(w * 4), 32'd0, 32'd0, 5'd1);
            read_back(5'd1, 32'd0, ok);
        end
        tally("reset: all registers and RAM words read zero", ok);
    endtask

    task automatic build_table();
        logic [31:0] rb;
        logic [31:0] rv;
        // word round trip
        add_row(K_STORE, lsu_pkg::F3_SW, 32'h100, 32'h20, 32'hdead_beef, 5'd1, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LW, 32'h110, 32'h10, 32'd0, 5'd1, 1'b0);
        // byte lanes with signed and unsigned loads
        add_row(K_STORE, lsu_pkg::F3_SW, 32'h200, 32'h0, 32'h1122_3344, 5'd1, 1'b0);
        add_row(K_STORE, lsu_pkg::F3_SB, 32'h200, 32'h1, 32'h0000_00a5, 5'd1, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LB, 32'h200, 32'h1, 32'd0, 5'd3, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LBU, 32'h201, 32'h0, 32'd0, 5'd4, 1'b0);
        add_row(K_STORE, lsu_pkg::F3_SB, 32'h200, 32'h0, 32'h0000_007f, 5'd1, 1'b0);
        add_row(K_STORE, lsu_pkg::F3_SB, 32'h202, 32'h0, 32'hffff_ff80, 5'd1, 1'b0);
        add_row(K_STORE, lsu_pkg::F3_SB, 32'h200, 32'h3, 32'hffff_ff01, 5'd1, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LB, 32'h200, 32'h0, 32'd0, 5'd3, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LB, 32'h202, 32'h0, 32'd0, 5'd3, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LBU, 32'h203, 32'h0, 32'd0, 5'd4, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LW, 32'h200, 32'h0, 32'd0, 5'd2, 1'b0);
        // halfwords with address bit 0 ignored
        add_row(K_STORE, lsu_pkg::F3_SH, 32'h300, 32'h0, 32'habcd_8001, 5'd1, 1'b0);
        add_row(K_STORE, lsu_pkg::F3_SH, 32'h300, 32'h3, 32'h1234_7ffe, 5'd1, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LH, 32'h300, 32'h1, 32'd0, 5'd5, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LHU, 32'h300, 32'h0, 32'd0, 5'd6, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LH, 32'h302, 32'h0, 32'd0, 5'd5, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LHU, 32'h303, 32'h0, 32'd0, 5'd6, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LW, 32'h300, 32'h0, 32'd0, 5'd7, 1'b0);
        // interrupt level blocks both stores and loads
        add_row(K_INT_STORE, lsu_pkg::F3_SW, 32'h120, 32'h0, 32'h5555_5555, 5'd1, 1'b0);
        add_row(K_LOAD, lsu_pkg::F3_LW, 32'h120, 32'h0, 32'd0, 5'd8, 1'b0);
        add_row(K_INT_LOAD, lsu_pkg::F3_LW, 32'h300, 32'h0, 32'd0, 5'd1, 1'b0);
        // x0 stays zero
        add_row(K_LOAD, lsu_pkg::F3_LW, 32'h120, 32'h0, 32'd0, 5'd0, 1'b0);
        // undefined funct3 writes zero
        add_row(K_LOAD, 3'd3, 32'h120, 32'h0, 32'd0, 5'd2, 1'b0);
        // store then load on consecutive cycles
        add_row(K_STORE, lsu_pkg::F3_SW, 32'h400, 32'h0, 32'hcafe_f00d, 5'd1, 1'b1);
        add_row(K_LOAD, lsu_pkg::F3_LW, 32'h400, 32'h0, 32'd0, 5'd9, 1'b0);
        add_row(K_STORE, lsu_pkg::F3_SB, 32'h401, 32'h0, 32'h0000_005a, 5'd1, 1'b1);
        add_row(K_LOAD, lsu_pkg::F3_LBU, 32'h3ff, 32'h2, 32'd0, 5'd10, 1'b0);
        // random bases wrapping onto the RAM
        for (int k = 0; k < 3; k++) begin
            rb = $random(seed);
            rv = $random(seed);
            add_row(K_STORE, lsu_pkg::F3_SW, rb, 32'h0, rv, 5'd1, 1'b0);
            add_row(K_LOAD, lsu_pkg::F3_LW, rb, 32'h0, 32'd0, 5'(11 + k), 1'b0);
        end
    endtask

    task automatic run_table();
        row_t        r;
        bit          ok;
        logic [31:0] addr;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            addr = r.base + r.offset;
            issue(r.kind, r.funct3, r.base, r.offset, r.rs2, r.rd);
            r.exp_rd = model_apply(r);
            if (r.b2b) begin
                $display("row %0d: issued back to back, checked by the next row", i);
            end else begin
                ok = 1'b1;
                read_back(r.rd, r.exp_rd, ok);
                tally($sformatf("row %0d: kind %0d funct3 %0d addr %08h rd x%0d",
                                i, r.kind, r.funct3, addr, r.rd), ok);
            end
        end
    endtask

    initial begin
        int waited;
        seed       = 32'h344e_8a05;
        pass_cnt   = 0;
        fail_cnt   = 0;
        req        = 1'b0;
        load       = 1'b0;
        store      = 1'b0;
        funct3     = 3'd0;
        base       = 32'd0;
        offset     = 32'd0;
        rs2_data   = 32'd0;
        rd_addr    = 5'd0;
        int_assert = 1'b0;
        rf_raddr   = 5'd0;
        for (int i = 0; i < 1024; i++) begin
            mem_model[i] = 8'd0;
        end
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = 32'd0;
        end
        waited = 0;
        while (arst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Finished with errors");
            $finish;
        end else begin
            build_table();
            check_reset();
            run_table();
            $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the load/store slice with decoder, AGU, data RAM and register file.
// Results are observed through the rf_raddr_i / rf_rdata_o read port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               req_i,
    input  logic                               load_i,
    input  logic                               store_i,
    input  logic [2:0]                         funct3_i,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]     base_i,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]     offset_i,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]     rs2_data_i,
    input  logic [lsu_pkg::REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  logic                               int_assert_i,
    input  logic [lsu_pkg::REG_ADDR_WIDTH-1:0] rf_raddr_i,
    output logic [lsu_pkg::DATA_WIDTH-1:0]     rf_rdata_o
);

    logic op_lb;
    logic op_lh;
    logic op_lw;
    logic op_lbu;
    logic op_lhu;
    logic op_sb;
    logic op_sh;
    logic op_sw;
    logic op_load;
    logic op_store;

    logic                               wb_we;
    logic [lsu_pkg::REG_ADDR_WIDTH-1:0] wb_addr;
    logic [lsu_pkg::DATA_WIDTH-1:0]     wb_data;

    lsu_mem_if #(
        .DATA_W (lsu_pkg::DATA_WIDTH),
        .ADDR_W (lsu_pkg::ADDR_WIDTH),
        .MASK_W (lsu_pkg::MASK_WIDTH)
    ) mem_bus ();

    lsu_op_decode u_decode (
        .funct3_i   (funct3_i),
        .load_i     (load_i),
        .store_i    (store_i),
        .op_lb_o    (op_lb),
        .op_lh_o    (op_lh),
        .op_lw_o    (op_lw),
        .op_lbu_o   (op_lbu),
        .op_lhu_o   (op_lhu),
        .op_sb_o    (op_sb),
        .op_sh_o    (op_sh),
        .op_sw_o    (op_sw),
        .op_load_o  (op_load),
        .op_store_o (op_store)
    );

    exu_agu_lsu u_agu (
        .req_mem_i      (req_i),
        .mem_op1_i      (base_i),
        .mem_op2_i      (offset_i),
        .mem_rs2_data_i (rs2_data_i),
        .mem_op_lb_i    (op_lb),
        .mem_op_lh_i    (op_lh),
        .mem_op_lw_i    (op_lw),
        .mem_op_lbu_i   (op_lbu),
        .mem_op_lhu_i   (op_lhu),
        .mem_op_sb_i    (op_sb),
        .mem_op_sh_i    (op_sh),
        .mem_op_sw_i    (op_sw),
        .mem_op_load_i  (op_load),
        .mem_op_store_i (op_store),
        .rd_addr_i      (rd_addr_i),
        .int_assert_i   (int_assert_i),
        .mem_o          (mem_bus.agu),
        .reg_wdata_o    (wb_data),
        .reg_we_o       (wb_we),
        .reg_waddr_o    (wb_addr)
    );

    lsu_data_ram u_ram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .mem_i    (mem_bus.ram)
    );

    lsu_reg_file u_rf (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (wb_we),
        .waddr_i  (wb_addr),
        .wdata_i  (wb_data),
        .raddr_i  (rf_raddr_i),
        .rdata_o  (rf_rdata_o)
    );

endmodule

`default_nettype wire

/* hdl/lsu_reg_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 integer register file, x0 reads as zero.
// One write port from the LSU and one read port for observation.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module lsu_reg_file (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               we_i,
    input  logic [lsu_pkg::REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]     wdata_i,
    input  logic [lsu_pkg::REG_ADDR_WIDTH-1:0] raddr_i,
    output logic [lsu_pkg::DATA_WIDTH-1:0]     rdata_o
);

    localparam int NUM_REGS = 2 ** lsu_pkg::REG_ADDR_WIDTH;

    logic [lsu_pkg::DATA_WIDTH-1:0] regs_q [NUM_REGS];
    logic                           wr_en;

    // x0 is never written
    assign wr_en = we_i & (waddr_i != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (wr_en) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // combinational read
    assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

`default_nettype wire

/* hdl/lsu_data_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-organised data RAM with byte-lane write mask.
// Writes land on the clock edge, reads are combinational on addr.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module lsu_data_ram (
    input  logic   clk_i,
    input  logic   arst_n_i,
    lsu_mem_if.ram mem_i
);

    logic [lsu_pkg::DATA_WIDTH-1:0]    mem_q [lsu_pkg::RAM_DEPTH];
    logic [lsu_pkg::RAM_IDX_WIDTH-1:0] word_idx;

    // byte address to word index, wraps modulo depth
    assign word_idx = mem_i.addr[lsu_pkg::RAM_IDX_WIDTH+1:2];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int w = 0; w < lsu_pkg::RAM_DEPTH; w++) begin
                mem_q[w] <= '0;
            end
        end else if (mem_i.req && mem_i.we) begin
            for (int b = 0; b < lsu_pkg::MASK_WIDTH; b++) begin
                if (mem_i.wmask[b]) begin
                    mem_q[word_idx][b*8 +: 8] <= mem_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // same-cycle read of the addressed word
    assign mem_i.rdata = mem_q[word_idx];

endmodule

`default_nettype wire

/* hdl/exu_agu_lsu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address generation and load/store unit, fully combinational.
// Drives the data-memory bus and the register-file writeback port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module exu_agu_lsu (
    input  logic                               req_mem_i,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]     mem_op1_i,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]     mem_op2_i,
    input  logic [lsu_pkg::DATA_WIDTH-1:0]     mem_rs2_data_i,
    input  logic                               mem_op_lb_i,
    input  logic                               mem_op_lh_i,
    input  logic                               mem_op_lw_i,
    input  logic                               mem_op_lbu_i,
    input  logic                               mem_op_lhu_i,
    input  logic                               mem_op_sb_i,
    input  logic                               mem_op_sh_i,
    input  logic                               mem_op_sw_i,
    input  logic                               mem_op_load_i,
    input  logic                               mem_op_store_i,
    input  logic [lsu_pkg::REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  logic                               int_assert_i,

    lsu_mem_if.agu                             mem_o,

    output logic [lsu_pkg::DATA_WIDTH-1:0]     reg_wdata_o,
    output logic                               reg_we_o,
    output logic [lsu_pkg::REG_ADDR_WIDTH-1:0] reg_waddr_o
);

    localparam int DW = lsu_pkg::DATA_WIDTH;
    localparam int MW = lsu_pkg::MASK_WIDTH;

    logic [lsu_pkg::ADDR_WIDTH-1:0] mem_addr;
    logic [1:0]                     addr_idx;
    logic                           valid_op;
    logic                           ld_wb;

    logic [MW-1:0] st_mask;
    logic [DW-1:0] st_data;
    logic [7:0]    ld_byte;
    logic [15:0]   ld_half;
    logic [DW-1:0] ld_data;

    assign mem_addr = mem_op1_i + mem_op2_i;
    assign addr_idx = mem_addr[1:0];

    // interrupt level kills the whole access
    assign valid_op = req_mem_i & (int_assert_i != lsu_pkg::INT_ASSERT);
    assign ld_wb    = valid_op & mem_op_load_i;

    // memory request side
    assign mem_o.req   = valid_op & (mem_op_load_i | mem_op_store_i);
    assign mem_o.we    = valid_op & mem_op_store_i;
    assign mem_o.addr  = mem_o.req ? mem_addr : '0;
    assign mem_o.wmask = mem_o.we ? st_mask : '0;
    assign mem_o.wdata = mem_o.we ? st_data : '0;

    // store lane placement
    always_comb begin
        st_mask = '0;
        st_data = '0;
        if (mem_op_sb_i) begin
            st_mask = MW'(1) << addr_idx;
            st_data = DW'(mem_rs2_data_i[7:0]) << {addr_idx, 3'b000};
        end else if (mem_op_sh_i) begin
            // halfwords only look at address bit 1
            if (addr_idx[1]) begin
                st_mask = 4'b1100;
                st_data = {mem_rs2_data_i[15:0], 16'h0000};
            end else begin
                st_mask = 4'b0011;
                st_data = {16'h0000, mem_rs2_data_i[15:0]};
            end
        end else if (mem_op_sw_i) begin
            st_mask = '1;
            st_data = mem_rs2_data_i;
        end
    end

    // pick the addressed byte and half out of the read word
    always_comb begin
        case (addr_idx)
            2'd0:    ld_byte = mem_o.rdata[7:0];
            2'd1:    ld_byte = mem_o.rdata[15:8];
            2'd2:    ld_byte = mem_o.rdata[23:16];
            default: ld_byte = mem_o.rdata[31:24];
        endcase
    end

    assign ld_half = addr_idx[1] ? mem_o.rdata[31:16] : mem_o.rdata[15:0];

    // sign or zero extension by width strobe
    always_comb begin
        ld_data = '0;
        if (mem_op_lb_i) begin
            ld_data = {{(DW-8){ld_byte[7]}}, ld_byte};
        end else if (mem_op_lbu_i) begin
            ld_data = {{(DW-8){1'b0}}, ld_byte};
        end else if (mem_op_lh_i) begin
            ld_data = {{(DW-16){ld_half[15]}}, ld_half};
        end else if (mem_op_lhu_i) begin
            ld_data = {{(DW-16){1'b0}}, ld_half};
        end else if (mem_op_lw_i) begin
            ld_data = mem_o.rdata;
        end
    end

    // writeback for any valid load, even with an unknown width
    assign reg_we_o    = ld_wb;
    assign reg_waddr_o = ld_wb ? rd_addr_i : '0;
    assign reg_wdata_o = ld_wb ? ld_data : '0;

endmodule

`default_nettype wire

/* hdl/lsu_op_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store operation decoder.
// Turns funct3 and the load/store class into one-hot strobes for the AGU.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module lsu_op_decode (
    input  logic [2:0] funct3_i,
    input  logic       load_i,
    input  logic       store_i,

    output logic       op_lb_o,
    output logic       op_lh_o,
    output logic       op_lw_o,
    output logic       op_lbu_o,
    output logic       op_lhu_o,
    output logic       op_sb_o,
    output logic       op_sh_o,
    output logic       op_sw_o,
    output logic       op_load_o,
    output logic       op_store_o
);

    logic is_load;
    logic is_store;

    // load wins if both class bits are set
    assign is_load  = load_i;
    assign is_store = store_i & ~load_i;

    assign op_load_o  = is_load;
    assign op_store_o = is_store;

    // load widths, undefined codes give no strobe
    assign op_lb_o  = is_load & (funct3_i == lsu_pkg::F3_LB);
    assign op_lh_o  = is_load & (funct3_i == lsu_pkg::F3_LH);
    assign op_lw_o  = is_load & (funct3_i == lsu_pkg::F3_LW);
    assign op_lbu_o = is_load & (funct3_i == lsu_pkg::F3_LBU);
    assign op_lhu_o = is_load & (funct3_i == lsu_pkg::F3_LHU);

    // store widths
    assign op_sb_o = is_store & (funct3_i == lsu_pkg::F3_SB);
    assign op_sh_o = is_store & (funct3_i == lsu_pkg::F3_SH);
    assign op_sw_o = is_store & (funct3_i == lsu_pkg::F3_SW);

endmodule

`default_nettype wire

/* hdl/lsu_mem_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data-memory bus between the AGU and the data RAM.
// No handshake: req is a per-cycle level, rdata follows addr.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

interface lsu_mem_if #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 32,
    parameter int MASK_W = 4
) ();

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [MASK_W-1:0] wmask;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;

    // requester side
    modport agu (output req, we, addr, wmask, wdata, input rdata);

    // memory side
    modport ram (input req, we, addr, wmask, wdata, output rdata);

endinterface

`default_nettype wire

/* hdl/lsu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants for the load/store slice.
// Modules refer to these by scoped name, e.g. lsu_pkg::DATA_WIDTH.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lsu_pkg;

    // datapath widths
    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int MASK_WIDTH     = DATA_WIDTH / 8;

    // data RAM geometry, word index taken from address bits 9:2
    localparam int RAM_DEPTH     = 256;
    localparam int RAM_IDX_WIDTH = $clog2(RAM_DEPTH);

    // load funct3 encodings (RV32I)
    localparam logic [2:0] F3_LB  = 3'd0;
    localparam logic [2:0] F3_LH  = 3'd1;
    localparam logic [2:0] F3_LW  = 3'd2;
    localparam logic [2:0] F3_LBU = 3'd4;
    localparam logic [2:0] F3_LHU = 3'd5;

    // store funct3 encodings
    localparam logic [2:0] F3_SB = 3'd0;
    localparam logic [2:0] F3_SH = 3'd1;
    localparam logic [2:0] F3_SW = 3'd2;

    // interrupt level that blocks a memory access
    localparam logic INT_ASSERT = 1'b1;

endpackage

`default_nettype wire
